// ==== Bender.yml ====
package:
  name: sub_mult

sources:
  - include_dirs:
      - .
    files:
      - sub_mult_pkg.sv
      - stream_skid_reg.sv
      - frame_aligner.sv
      - sub_mult_datapath.sv
      - sub_mult_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sub_mult_asserts.sv
      - tb_sub_mult.sv

// ==== frame_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_aligner (
  input  sub_mult_pkg::sample_beat_t data_beat,
  input  logic                       data_valid,
  output logic                       data_ready,
  input  sub_mult_pkg::sample_beat_t grid_beat,
  input  logic                       grid_valid,
  output logic                       grid_ready,
  input  sub_mult_pkg::scale_beat_t  scale_beat,
  input  logic                       scale_valid,
  output logic                       scale_ready,
  output sub_mult_pkg::operand_set_t ops,
  output logic                       ops_valid,
  input  logic                       ops_ready
);

  logic all_valid;
  logic fire;
  logic frame_end;
  logic data_hold;
  logic grid_hold;
  logic scale_hold;

  // Join of the three streams
  assign all_valid = data_valid & grid_valid & scale_valid;
  assign fire      = all_valid & ops_ready;

  // Frame closes only when every stream sits on its last beat
  assign frame_end = data_beat.last & grid_beat.last & scale_beat.last;

  // A stream that reached its last beat early keeps it for reuse
  assign data_hold  = data_beat.last & ~frame_end;
  assign grid_hold  = grid_beat.last & ~frame_end;
  assign scale_hold = scale_beat.last & ~frame_end;

  assign data_ready  = fire & ~data_hold;
  assign grid_ready  = fire & ~grid_hold;
  assign scale_ready = fire & ~scale_hold;

  assign ops_valid = all_valid;
  assign ops.data  = data_beat.value;
  assign ops.grid  = grid_beat.value;
  assign ops.scale = scale_beat.value;
  assign ops.last  = frame_end;

endmodule

`default_nettype wire

// ==== stream_skid_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_skid_reg #(
  parameter type beat_t = logic
) (
  input  logic  clk,
  input  logic  rst_n,
  input  beat_t s_beat,
  input  logic  s_valid,
  output logic  s_ready,
  output beat_t m_beat,
  output logic  m_valid,
  input  logic  m_ready
);
  import sub_mult_pkg::*;

  skid_state_e state;
  skid_state_e state_next;
  beat_t       skid_beat;
  logic        push;
  logic        pop;
  logic        load_main;
  logic        load_skid;
  logic        main_from_skid;

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  // Occupancy FSM, m_beat is always the oldest entry
  always_comb begin
    state_next     = state;
    load_main      = 1'b0;
    load_skid      = 1'b0;
    main_from_skid = 1'b0;
    case (state)
      SKID_EMPTY: begin
        if (push) begin
          load_main  = 1'b1;
          state_next = SKID_ONE;
        end
      end
      SKID_ONE: begin
        if (push && pop) begin
          load_main = 1'b1;
        end else if (push) begin
          // Output stalled, park the new beat
          load_skid  = 1'b1;
          state_next = SKID_TWO;
        end else if (pop) begin
          state_next = SKID_EMPTY;
        end
      end
      SKID_TWO: begin
        if (pop) begin
          main_from_skid = 1'b1;
          state_next     = SKID_ONE;
        end
      end
      default: state_next = SKID_EMPTY;
    endcase
  end

  // Handshake flags are flopped from the next state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= SKID_EMPTY;
      s_ready <= 1'b1;
      m_valid <= 1'b0;
    end else begin
      state   <= state_next;
      s_ready <= (state_next != SKID_TWO);
      m_valid <= (state_next != SKID_EMPTY);
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      m_beat <= s_beat;
    end else if (main_from_skid) begin
      m_beat <= skid_beat;
    end
    if (load_skid) begin
      skid_beat <= s_beat;
    end
  end

endmodule

`default_nettype wire

// ==== sub_mult_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_mult_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     s_data_ready,
  input logic                     s_grid_ready,
  input logic                     s_scale_ready,
  input sub_mult_pkg::rslt_beat_t m_rslt,
  input logic                     m_rslt_valid,
  input logic                     m_rslt_ready
);

  int unsigned violations = 0;

  // Result valid stays up until the beat is taken
  a_rslt_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    m_rslt_valid && !m_rslt_ready |=> m_rslt_valid)
  else begin
    violations++;
    $error("m_rslt_valid dropped before the beat transferred");
  end

  // Stalled beat must not change
  a_rslt_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_rslt_valid && !m_rslt_ready |=> $stable(m_rslt))
  else begin
    violations++;
    $error("m_rslt changed while stalled");
  end

  // A valid result carries no unknown bits
  a_rslt_known: assert property (@(posedge clk) disable iff (!rst_n)
    m_rslt_valid |-> !$isunknown(m_rslt))
  else begin
    violations++;
    $error("m_rslt holds unknown bits while valid");
  end

  // Empty skids right after reset
  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !m_rslt_valid && s_data_ready && s_grid_ready && s_scale_ready)
  else begin
    violations++;
    $error("Stream flags wrong after reset release");
  end

endmodule

bind sub_mult_top sub_mult_asserts i_sub_mult_asserts (
  .clk(clk), .rst_n(rst_n),
  .s_data_ready(s_data_ready),
  .s_grid_ready(s_grid_ready), .s_scale_ready(s_scale_ready),
  .m_rslt(m_rslt), .m_rslt_valid(m_rslt_valid), .m_rslt_ready(m_rslt_ready)
);

`default_nettype wire

// ==== sub_mult_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sub_mult_defs.svh"

module sub_mult_datapath (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sub_mult_pkg::operand_set_t ops,
  input  logic                       ops_valid,
  output logic                       ops_ready,
  output sub_mult_pkg::rslt_beat_t   rslt,
  output logic                       rslt_valid,
  input  logic                       rslt_ready
);
  import sub_mult_pkg::*;

  prod_t diff;
  prod_t prod;
  logic  load;

  // Full-width arithmetic, the difference may need one extra bit
  assign diff = prod_t'(ops.data) - prod_t'(ops.grid);
  assign prod = diff * prod_t'(ops.scale);

  // Stage frees up in the same cycle its result leaves
  assign ops_ready = ~rslt_valid | rslt_ready;
  assign load      = ops_valid & ops_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rslt_valid <= 1'b0;
    end else if (load) begin
      rslt_valid <= 1'b1;
    end else if (rslt_ready) begin
      rslt_valid <= 1'b0;
    end
  end

  // Rescale by dropping the low product bits, upper bits truncated
  always_ff @(posedge clk) begin
    if (load) begin
      rslt.value <= prod[RSLT_LSB +: `SM_RSLT_W];
      rslt.last  <= ops.last;
    end
  end

endmodule

`default_nettype wire

// ==== sub_mult_defs.svh ====
`ifndef SUB_MULT_DEFS_SVH
`define SUB_MULT_DEFS_SVH

// Data and grid samples share one fixed-point format
`define SM_DATA_W      16
`define SM_DATA_FRAC   12

// Scale sample format
`define SM_SCALE_W     16
`define SM_SCALE_FRAC  12

// Result format after the rescale
`define SM_RSLT_W      16
`define SM_RSLT_FRAC   12

`endif

// ==== sub_mult_pkg.sv ====
`default_nettype none

`include "sub_mult_defs.svh"

package sub_mult_pkg;

  // Scalar sample types, all two's complement
  typedef logic signed [`SM_DATA_W-1:0]             data_t;
  typedef logic signed [`SM_SCALE_W-1:0]            scale_t;
  typedef logic signed [`SM_RSLT_W-1:0]             rslt_t;
  typedef logic signed [`SM_DATA_W+`SM_SCALE_W-1:0] prod_t;

  // First product bit that lands in the result LSB
  localparam int RSLT_LSB = `SM_DATA_FRAC + `SM_SCALE_FRAC - `SM_RSLT_FRAC;

  typedef struct packed {
    data_t value;
    logic  last;
  } sample_beat_t;

  typedef struct packed {
    scale_t value;
    logic   last;
  } scale_beat_t;

  // One joined beat of all three streams
  typedef struct packed {
    data_t  data;
    data_t  grid;
    scale_t scale;
    logic   last;
  } operand_set_t;

  typedef struct packed {
    rslt_t value;
    logic  last;
  } rslt_beat_t;

  typedef enum logic [1:0] {
    SKID_EMPTY,
    SKID_ONE,
    SKID_TWO
  } skid_state_e;

endpackage

`default_nettype wire

// ==== sub_mult_top.f ====
+incdir+.
sub_mult_pkg.sv
stream_skid_reg.sv
frame_aligner.sv
sub_mult_datapath.sv
sub_mult_top.sv
sub_mult_asserts.sv
tb_sub_mult.sv

// ==== sub_mult_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_mult_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sub_mult_pkg::sample_beat_t s_data,
  input  logic                       s_data_valid,
  output logic                       s_data_ready,
  input  sub_mult_pkg::sample_beat_t s_grid,
  input  logic                       s_grid_valid,
  output logic                       s_grid_ready,
  input  sub_mult_pkg::scale_beat_t  s_scale,
  input  logic                       s_scale_valid,
  output logic                       s_scale_ready,
  output sub_mult_pkg::rslt_beat_t   m_rslt,
  output logic                       m_rslt_valid,
  input  logic                       m_rslt_ready
);
  import sub_mult_pkg::*;

  sample_beat_t data_beat;
  logic         data_valid;
  logic         data_ready;
  sample_beat_t grid_beat;
  logic         grid_valid;
  logic         grid_ready;
  scale_beat_t  scale_beat;
  logic         scale_valid;
  logic         scale_ready;
  operand_set_t ops;
  logic         ops_valid;
  logic         ops_ready;
  rslt_beat_t   rslt;
  logic         rslt_valid;
  logic         rslt_ready;

  // Input skid stage
  stream_skid_reg #(.beat_t(sample_beat_t)) i_data_skid (
    .clk(clk), .rst_n(rst_n),
    .s_beat(s_data), .s_valid(s_data_valid), .s_ready(s_data_ready),
    .m_beat(data_beat), .m_valid(data_valid), .m_ready(data_ready)
  );

  stream_skid_reg #(.beat_t(sample_beat_t)) i_grid_skid (
    .clk(clk), .rst_n(rst_n),
    .s_beat(s_grid), .s_valid(s_grid_valid), .s_ready(s_grid_ready),
    .m_beat(grid_beat), .m_valid(grid_valid), .m_ready(grid_ready)
  );

  stream_skid_reg #(.beat_t(scale_beat_t)) i_scale_skid (
    .clk(clk), .rst_n(rst_n),
    .s_beat(s_scale), .s_valid(s_scale_valid), .s_ready(s_scale_ready),
    .m_beat(scale_beat), .m_valid(scale_valid), .m_ready(scale_ready)
  );

  // Join and last-beat hold
  frame_aligner i_frame_aligner (
    .data_beat(data_beat), .data_valid(data_valid), .data_ready(data_ready),
    .grid_beat(grid_beat), .grid_valid(grid_valid), .grid_ready(grid_ready),
    .scale_beat(scale_beat), .scale_valid(scale_valid), .scale_ready(scale_ready),
    .ops(ops), .ops_valid(ops_valid), .ops_ready(ops_ready)
  );

  sub_mult_datapath i_datapath (
    .clk(clk), .rst_n(rst_n),
    .ops(ops), .ops_valid(ops_valid), .ops_ready(ops_ready),
    .rslt(rslt), .rslt_valid(rslt_valid), .rslt_ready(rslt_ready)
  );

  // Output skid stage
  stream_skid_reg #(.beat_t(rslt_beat_t)) i_rslt_skid (
    .clk(clk), .rst_n(rst_n),
    .s_beat(rslt), .s_valid(rslt_valid), .s_ready(rslt_ready),
    .m_beat(m_rslt), .m_valid(m_rslt_valid), .m_ready(m_rslt_ready)
  );

endmodule

`default_nettype wire

// ==== tb_sub_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sub_mult_defs.svh"

module tb_sub_mult;
  import sub_mult_pkg::*;

  localparam int N_FRAMES = 5;
  localparam int MAX_LEN  = 4;
  localparam int SHIFT    = `SM_DATA_FRAC + `SM_SCALE_FRAC - `SM_RSLT_FRAC;

  logic         clk = 1'b0;
  logic         rst_n;
  sample_beat_t s_data;
  logic         s_data_valid;
  logic         s_data_ready;
  sample_beat_t s_grid;
  logic         s_grid_valid;
  logic         s_grid_ready;
  scale_beat_t  s_scale;
  logic         s_scale_valid;
  logic         s_scale_ready;
  rslt_beat_t   m_rslt;
  logic         m_rslt_valid;
  logic         m_rslt_ready = 1'b0;

  // Frame table, Q4.12 values, unused slots are zero
  string  frame_name [N_FRAMES] = '{"equal_len", "unequal_len", "signed_ops",
                                    "single_beat", "unequal_mixed"};
  int     data_len   [N_FRAMES] = '{3, 4, 3, 1, 2};
  int     grid_len   [N_FRAMES] = '{3, 2, 3, 1, 3};
  int     scale_len  [N_FRAMES] = '{3, 1, 3, 1, 4};
  data_t  data_tab   [N_FRAMES][MAX_LEN] = '{
    '{16'h1000, 16'h2000, 16'h0800, 16'h0000},
    '{16'h0300, 16'h0600, 16'h0900, 16'h0C00},
    '{16'h0800, 16'hF000, 16'h7FFF, 16'h0000},
    '{16'hFFFF, 16'h0000, 16'h0000, 16'h0000},
    '{16'h1234, 16'hF321, 16'h0000, 16'h0000}};
  data_t  grid_tab   [N_FRAMES][MAX_LEN] = '{
    '{16'h0400, 16'h1000, 16'h0100, 16'h0000},
    '{16'h0100, 16'h0200, 16'h0000, 16'h0000},
    '{16'h1800, 16'h0400, 16'h8000, 16'h0000},
    '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0111, 16'h0222, 16'hFDDD, 16'h0000}};
  scale_t scale_tab  [N_FRAMES][MAX_LEN] = '{
    '{16'h1000, 16'h0800, 16'h1800, 16'h0000},
    '{16'h2000, 16'h0000, 16'h0000, 16'h0000},
    '{16'hE000, 16'hF800, 16'h7FFF, 16'h0000},
    '{16'h0001, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0FFF, 16'hC000, 16'h0123, 16'hF00F}};

  // Expected result stream in output order
  rslt_t exp_value [$];
  logic  exp_last  [$];
  int    exp_frame [$];
  int    exp_beat  [$];

  int   n_expected  = 0;
  int   n_received  = 0;
  int   cycle_count = 0;
  int   cycle_limit = 0;
  logic start       = 1'b0;

  sub_mult_top i_sub_mult_top (
    .clk(clk), .rst_n(rst_n),
    .s_data(s_data), .s_data_valid(s_data_valid), .s_data_ready(s_data_ready),
    .s_grid(s_grid), .s_grid_valid(s_grid_valid), .s_grid_ready(s_grid_ready),
    .s_scale(s_scale), .s_scale_valid(s_scale_valid), .s_scale_ready(s_scale_ready),
    .m_rslt(m_rslt), .m_rslt_valid(m_rslt_valid), .m_rslt_ready(m_rslt_ready)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_rslt(input string name, input rslt_t expected, input rslt_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] %s value: expected %0d (0x%h), actual %0d (0x%h)",
                         name, expected, expected, actual, actual));
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] %s last: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // (data - grid) * scale, low fraction bits dropped, upper bits truncated
  function automatic rslt_t compute_expected(input data_t d, input data_t g, input scale_t s);
    longint diff;
    longint prod;
    diff = longint'(d) - longint'(g);
    prod = diff * longint'(s);
    return rslt_t'(prod >>> SHIFT);
  endfunction

  // Shorter streams repeat their last value until the longest one ends
  task automatic build_expected();
    int n;
    int di;
    int gi;
    int si;
    for (int f = 0; f < N_FRAMES; f++) begin
      n = data_len[f];
      if (grid_len[f] > n) n = grid_len[f];
      if (scale_len[f] > n) n = scale_len[f];
      for (int i = 0; i < n; i++) begin
        di = (i < data_len[f]) ? i : data_len[f] - 1;
        gi = (i < grid_len[f]) ? i : grid_len[f] - 1;
        si = (i < scale_len[f]) ? i : scale_len[f] - 1;
        exp_value.push_back(compute_expected(data_tab[f][di], grid_tab[f][gi],
                                             scale_tab[f][si]));
        exp_last.push_back(i == n - 1);
        exp_frame.push_back(f);
        exp_beat.push_back(i);
      end
    end
    n_expected = exp_value.size();
  endtask

  initial begin : drive_data
    s_data       = '0;
    s_data_valid = 1'b0;
    wait (start);
    @(posedge clk);
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int b = 0; b < data_len[f]; b++) begin
        s_data.value <= data_tab[f][b];
        s_data.last  <= (b == data_len[f] - 1);
        s_data_valid <= 1'b1;
        @(posedge clk);
        while (!s_data_ready) @(posedge clk);
      end
    end
    s_data_valid <= 1'b0;
  end

  initial begin : drive_grid
    s_grid       = '0;
    s_grid_valid = 1'b0;
    wait (start);
    @(posedge clk);
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int b = 0; b < grid_len[f]; b++) begin
        s_grid.value <= grid_tab[f][b];
        s_grid.last  <= (b == grid_len[f] - 1);
        s_grid_valid <= 1'b1;
        @(posedge clk);
        while (!s_grid_ready) @(posedge clk);
      end
    end
    s_grid_valid <= 1'b0;
  end

  initial begin : drive_scale
    s_scale       = '0;
    s_scale_valid = 1'b0;
    wait (start);
    @(posedge clk);
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int b = 0; b < scale_len[f]; b++) begin
        s_scale.value <= scale_tab[f][b];
        s_scale.last  <= (b == scale_len[f] - 1);
        s_scale_valid <= 1'b1;
        @(posedge clk);
        while (!s_scale_ready) @(posedge clk);
      end
    end
    s_scale_valid <= 1'b0;
  end

  // Random back-pressure on the result stream
  initial begin : drive_backpressure
    void'($urandom(93));
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        m_rslt_ready <= 1'b0;
      end else begin
        m_rslt_ready <= (($urandom % 4) != 0);
      end
    end
  end

  always @(posedge clk) begin : watch_rslt
    string name;
    if (rst_n && m_rslt_valid && m_rslt_ready) begin
      if (exp_value.size() == 0) begin
        fail_run("A result beat arrived while no result was expected");
      end else begin
        name = $sformatf("%s beat %0d", frame_name[exp_frame[0]], exp_beat[0]);
        check_rslt(name, exp_value[0], m_rslt.value);
        check_last(name, exp_last[0], m_rslt.last);
        void'(exp_value.pop_front());
        void'(exp_last.pop_front());
        void'(exp_frame.pop_front());
        void'(exp_beat.pop_front());
        n_received++;
      end
    end
  end

  // Any protocol assertion failure ends the run at once
  initial begin : stop_on_assert
    wait (i_sub_mult_top.i_sub_mult_asserts.violations != 0);
    fail_run("A protocol assertion on the DUT streams failed");
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                         cycle_count, n_received, n_expected));
    end
  end

  initial begin
    rst_n = 1'b0;
    build_expected();
    cycle_limit = 20 * n_expected + 200;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("after reset m_rslt_valid", 1'b0, m_rslt_valid);
    check_flag("after reset s_data_ready", 1'b1, s_data_ready);
    check_flag("after reset s_grid_ready", 1'b1, s_grid_ready);
    check_flag("after reset s_scale_ready", 1'b1, s_scale_ready);
    start = 1'b1;
    wait (n_received == n_expected);
    // Idle a few cycles to catch stray beats
    repeat (10) @(posedge clk);
    if (i_sub_mult_top.i_sub_mult_asserts.violations != 0) begin
      fail_run($sformatf("%0d protocol assertion failures",
                         i_sub_mult_top.i_sub_mult_asserts.violations));
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
